// ==== exec_stage.f ====
+incdir+tb
verilog/exec_pkg.sv
verilog/exec_latch.sv
verilog/int_alu.sv
verilog/mem_agen.sv
verilog/branch_unit.sv
verilog/exec_stage.sv
tb/tb_exec_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the exec_stage testbench with Verilator and runs it, output goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timescale 1ns/1ps --top-module tb_exec_stage -f exec_stage.f \
    --Mdir obj_dir -o sim_exec_stage > sim.log 2>&1 \
    && ./obj_dir/sim_exec_stage >> sim.log 2>&1

cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

exec_pkg::xlen_t     exp_exec_pc, exp_reg_w_data, exp_mem_r_addr, exp_jmp_pc;
exec_pkg::xlen_t     exp_mem_w_addr, exp_mem_w_data;
exec_pkg::reg_addr_t exp_reg_w_rd, exp_mem_r_rd;
exec_pkg::strb_t     exp_mem_r_strb, exp_mem_w_strb;
logic                exp_reg_w_en, exp_mem_r_en, exp_mem_r_signed, exp_mem_w_en, exp_jmp_do;

function automatic exec_pkg::xlen_t sext_i(input exec_pkg::xlen_t v);
    return $signed({v[11:0], 20'b0}) >>> 20;
endfunction

function automatic exec_pkg::xlen_t sext_b(input exec_pkg::xlen_t v);
    return $signed({v[12:1], 20'b0}) >>> 19;    // bit 0 ends up zero
endfunction

task automatic set_write(input logic en, input exec_pkg::reg_addr_t rd,
                         input exec_pkg::xlen_t data);
    exp_reg_w_en   = en;
    exp_reg_w_rd   = en ? rd : '0;
    exp_reg_w_data = en ? data : '0;
endtask

// expected outputs for one latched instruction
task automatic predict(input exec_pkg::xlen_t pc_v, input exec_pkg::op_t op,
                       input exec_pkg::reg_addr_t rd, input exec_pkg::xlen_t a,
                       input exec_pkg::xlen_t rs2_v, input exec_pkg::xlen_t imm_v);
    logic [6:0]      major;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic            reg_form;
    logic            ok;
    logic [4:0]      sh;
    exec_pkg::xlen_t b;
    exec_pkg::xlen_t r;
    exec_pkg::xlen_t ea;
    major    = op[16:10];
    f3       = op[9:7];
    f7       = op[6:0];
    reg_form = (major == exec_pkg::OPC_OP);
    b        = reg_form ? rs2_v : sext_i(imm_v);
    sh       = reg_form ? rs2_v[4:0] : imm_v[4:0];
    ea       = a + sext_i(imm_v);
    ok       = !reg_form || f7 == 7'd0;
    r        = '0;
    {exp_reg_w_data, exp_mem_r_addr, exp_jmp_pc, exp_mem_w_addr, exp_mem_w_data} = '0;
    {exp_reg_w_rd, exp_mem_r_rd, exp_mem_r_strb, exp_mem_w_strb} = '0;
    {exp_reg_w_en, exp_mem_r_en, exp_mem_r_signed, exp_mem_w_en, exp_jmp_do} = '0;
    exp_exec_pc = pc_v;
    case (f3)
        3'd0: begin
            r  = (reg_form && f7 == exec_pkg::FUNCT7_ALT) ? a - b : a + b;
            ok = !reg_form || f7 == 7'd0 || f7 == exec_pkg::FUNCT7_ALT;
        end
        3'd1: begin
            r  = a << sh;
            ok = (f7 == 7'd0);
        end
        3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: r = (a < b) ? 32'd1 : 32'd0;
        3'd4: r = a ^ b;
        3'd5: begin
            if (f7 == exec_pkg::FUNCT7_ALT)
                r = $signed(a) >>> sh;
            else
                r = a >> sh;
            ok = (f7 == 7'd0) || (f7 == exec_pkg::FUNCT7_ALT);
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    case (major)
        exec_pkg::OPC_OP, exec_pkg::OPC_OP_IMM: set_write(ok, rd, r);
        exec_pkg::OPC_LUI:   set_write(1'b1, rd, imm_v & 32'hFFFF_F000);
        exec_pkg::OPC_AUIPC: set_write(1'b1, rd, pc_v + (imm_v & 32'hFFFF_F000));
        exec_pkg::OPC_JAL: begin
            set_write(1'b1, rd, pc_v + 32'd4);
            exp_jmp_do = 1'b1;
            exp_jmp_pc = pc_v + imm_v;
        end
        exec_pkg::OPC_JALR: begin
            if (f3 == 3'd0) begin
                set_write(1'b1, rd, pc_v + 32'd4);
                exp_jmp_do = 1'b1;
                exp_jmp_pc = ea & 32'hFFFF_FFFE;
            end
        end
        exec_pkg::OPC_LOAD: begin
            case (f3)
                3'd0, 3'd4: exp_mem_r_strb = 4'b0001;
                3'd1, 3'd5: exp_mem_r_strb = 4'b0011;
                3'd2:       exp_mem_r_strb = 4'b1111;
                default:    exp_mem_r_strb = 4'b0000;
            endcase
            exp_mem_r_en     = (exp_mem_r_strb != 4'b0000);
            exp_mem_r_signed = (f3 == 3'd0) || (f3 == 3'd1);    // lb, lh
            exp_mem_r_rd     = exp_mem_r_en ? rd : '0;
            exp_mem_r_addr   = exp_mem_r_en ? ea : '0;
        end
        exec_pkg::OPC_STORE: begin
            case (f3)
                3'd0:    exp_mem_w_strb = 4'b0001;
                3'd1:    exp_mem_w_strb = 4'b0011;
                3'd2:    exp_mem_w_strb = 4'b1111;
                default: exp_mem_w_strb = 4'b0000;
            endcase
            exp_mem_w_en   = (exp_mem_w_strb != 4'b0000);
            exp_mem_w_addr = exp_mem_w_en ? ea : '0;
            exp_mem_w_data = exp_mem_w_en ? rs2_v : '0;
        end
        exec_pkg::OPC_BRANCH: begin
            exp_jmp_pc = pc_v + sext_b(imm_v);
            case (f3)
                3'd0:    exp_jmp_do = (a == rs2_v);
                3'd1:    exp_jmp_do = (a != rs2_v);
                3'd4:    exp_jmp_do = ($signed(a) < $signed(rs2_v));
                3'd5:    exp_jmp_do = ($signed(a) >= $signed(rs2_v));
                3'd6:    exp_jmp_do = (a < rs2_v);
                3'd7:    exp_jmp_do = (a >= rs2_v);
                default: exp_jmp_pc = '0;      // f3 2 and 3 are no branch
            endcase
        end
        default: ;
    endcase
endtask

`endif

// ==== tb/tb_exec_stage.sv ====
module tb_exec_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 3;
    localparam int TEST_CYCLES  = 4000;
    localparam int WATCHDOG_NS  =
        (TEST_CYCLES * CLK_PERIOD + (RESET_CYCLES + IDLE_CYCLES) * CLK_PERIOD) * 3 / 2;
    localparam int PH_RESET = 0;
    localparam int PH_IDLE  = 1;
    localparam int PH_RUN   = 2;

    logic                CLK, rst, flush, stall, mem_wait, allow;
    exec_pkg::xlen_t     pc, rs1_data, rs2_data, imm;
    exec_pkg::op_t       opcode;
    exec_pkg::reg_addr_t rd_addr;
    exec_pkg::xlen_t     exec_pc, reg_w_data, mem_r_addr, mem_w_addr, mem_w_data, jmp_pc;
    exec_pkg::reg_addr_t reg_w_rd, mem_r_rd;
    exec_pkg::strb_t     mem_r_strb, mem_w_strb;
    logic                reg_w_en, mem_r_en, mem_r_signed, mem_w_en, jmp_do;

    exec_pkg::xlen_t     cp_pc, cp_rs1, cp_rs2, cp_imm;   // copy of the latch
    exec_pkg::op_t       cp_op;
    exec_pkg::reg_addr_t cp_rd;
    int                  phase;

    `include "exec_model.svh"

    exec_stage exec_stage_i (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        $display("Errors found");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_xlen(input string name, input exec_pkg::xlen_t got,
                              input exec_pkg::xlen_t exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    task automatic check_reg_addr(input string name, input exec_pkg::reg_addr_t got,
                                  input exec_pkg::reg_addr_t exp);
        if (got !== exp)
            report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_strb(input string name, input exec_pkg::strb_t got,
                              input exec_pkg::strb_t exp);
        if (got !== exp)
            report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic clear_copy();
        cp_pc  = '0;
        cp_op  = '0;
        cp_rd  = '0;
        cp_rs1 = '0;
        cp_rs2 = '0;
        cp_imm = '0;
    endtask

    // same priority as the stage: rst/flush, mem_wait, stall, allow
    task automatic update_copy();
        if (rst || flush) begin
            clear_copy();
        end else if (!mem_wait) begin
            if (stall || !allow) begin
                clear_copy();
            end else begin
                cp_pc  = pc;
                cp_op  = opcode;
                cp_rd  = rd_addr;
                cp_rs1 = rs1_data;
                cp_rs2 = rs2_data;
                cp_imm = imm;
            end
        end
    endtask

    task automatic drive_inputs();
        int unsigned pick;
        logic [6:0]  major;
        logic [2:0]  f3;
        logic [6:0]  f7;
        pick = $urandom % 12;
        case (pick)
            0:       major = exec_pkg::OPC_OP;
            1:       major = exec_pkg::OPC_OP_IMM;
            2:       major = exec_pkg::OPC_LUI;
            3:       major = exec_pkg::OPC_AUIPC;
            4:       major = exec_pkg::OPC_JAL;
            5:       major = exec_pkg::OPC_JALR;
            6:       major = exec_pkg::OPC_LOAD;
            7:       major = exec_pkg::OPC_STORE;
            8, 9:    major = exec_pkg::OPC_BRANCH;
            default: major = 7'($urandom);      // mostly unsupported
        endcase
        f3 = 3'($urandom);
        if (major == exec_pkg::OPC_JALR && $urandom % 2 == 0)
            f3 = 3'd0;
        pick = $urandom % 8;
        if (pick < 5)
            f7 = 7'd0;
        else if (pick < 7)
            f7 = exec_pkg::FUNCT7_ALT;
        else
            f7 = 7'($urandom);
        opcode   = {major, f3, f7};
        pc       = $urandom & 32'hFFFF_FFFC;
        rd_addr  = 5'($urandom);
        rs1_data = $urandom;
        rs2_data = ($urandom % 4 == 0) ? rs1_data : $urandom;   // equal operands for beq
        imm      = $urandom;
        rst      = (phase == PH_RESET);
        flush    = (phase == PH_RUN) && ($urandom % 24 == 0);
        stall    = (phase == PH_RUN) && ($urandom % 16 == 0);
        mem_wait = (phase == PH_RUN) && ($urandom % 6 == 0);
        allow    = (phase != PH_IDLE) && ($urandom % 10 != 0);
    endtask

    task automatic check_outputs();
        predict(cp_pc, cp_op, cp_rd, cp_rs1, cp_rs2, cp_imm);
        check_xlen("exec_pc", exec_pc, exp_exec_pc);
        check_bit("reg_w_en", reg_w_en, exp_reg_w_en);
        check_reg_addr("reg_w_rd", reg_w_rd, exp_reg_w_rd);
        check_xlen("reg_w_data", reg_w_data, exp_reg_w_data);
        check_bit("mem_r_en", mem_r_en, exp_mem_r_en);
        check_reg_addr("mem_r_rd", mem_r_rd, exp_mem_r_rd);
        check_xlen("mem_r_addr", mem_r_addr, exp_mem_r_addr);
        check_strb("mem_r_strb", mem_r_strb, exp_mem_r_strb);
        check_bit("mem_r_signed", mem_r_signed, exp_mem_r_signed);
        check_bit("mem_w_en", mem_w_en, exp_mem_w_en);
        check_xlen("mem_w_addr", mem_w_addr, exp_mem_w_addr);
        check_strb("mem_w_strb", mem_w_strb, exp_mem_w_strb);
        check_xlen("mem_w_data", mem_w_data, exp_mem_w_data);
        check_bit("jmp_do", jmp_do, exp_jmp_do);
        check_xlen("jmp_pc", jmp_pc, exp_jmp_pc);
    endtask

    // entered 5 ns after a rising edge, left 5 ns after the next one
    task automatic run_cycle();
        drive_inputs();
        #(CLK_PERIOD - 10);
        check_outputs();
        @(posedge CLK);
        update_copy();
        #5;
    endtask

    initial begin
        void'($urandom(83235));
        phase    = PH_RESET;
        rst      = 1'b1;
        flush    = 1'b0;
        stall    = 1'b0;
        mem_wait = 1'b0;
        allow    = 1'b0;
        pc       = '0;
        opcode   = '0;
        rd_addr  = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm      = '0;
        clear_copy();
        @(posedge CLK);
        update_copy();
        #5;
        repeat (RESET_CYCLES - 1) run_cycle();
        phase = PH_IDLE;                    // allow low, outputs must stay idle
        repeat (IDLE_CYCLES) run_cycle();
        phase = PH_RUN;
        repeat (TEST_CYCLES) run_cycle();
        $display("No errors");
        $finish;
    end

endmodule

// ==== verilog/exec_stage.sv ====
module exec_stage (
    input  logic                CLK,
    input  logic                rst,
    input  logic                flush,
    input  logic                stall,
    input  logic                mem_wait,
    input  logic                allow,
    input  exec_pkg::xlen_t     pc,
    input  exec_pkg::op_t       opcode,
    input  exec_pkg::reg_addr_t rd_addr,
    input  exec_pkg::xlen_t     rs1_data,
    input  exec_pkg::xlen_t     rs2_data,
    input  exec_pkg::xlen_t     imm,
    output exec_pkg::xlen_t     exec_pc,
    output logic                reg_w_en,
    output exec_pkg::reg_addr_t reg_w_rd,
    output exec_pkg::xlen_t     reg_w_data,
    output logic                mem_r_en,
    output exec_pkg::reg_addr_t mem_r_rd,
    output exec_pkg::xlen_t     mem_r_addr,
    output exec_pkg::strb_t     mem_r_strb,
    output logic                mem_r_signed,
    output logic                mem_w_en,
    output exec_pkg::xlen_t     mem_w_addr,
    output exec_pkg::strb_t     mem_w_strb,
    output exec_pkg::xlen_t     mem_w_data,
    output logic                jmp_do,
    output exec_pkg::xlen_t     jmp_pc
);

    exec_pkg::xlen_t     lat_pc;
    exec_pkg::op_t       lat_op;
    exec_pkg::reg_addr_t lat_rd;
    exec_pkg::xlen_t     lat_rs1;
    exec_pkg::xlen_t     lat_rs2;
    exec_pkg::xlen_t     lat_imm;

    exec_latch latch_i (
        .CLK(CLK), .rst(rst), .flush(flush), .stall(stall),
        .mem_wait(mem_wait), .allow(allow),
        .pc(pc), .opcode(opcode), .rd_addr(rd_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .lat_pc(lat_pc), .lat_op(lat_op), .lat_rd(lat_rd),
        .lat_rs1(lat_rs1), .lat_rs2(lat_rs2), .lat_imm(lat_imm)
    );

    assign exec_pc = lat_pc;

    int_alu alu_i (
        .lat_pc(lat_pc), .lat_op(lat_op), .lat_rd(lat_rd),
        .lat_rs1(lat_rs1), .lat_rs2(lat_rs2), .lat_imm(lat_imm),
        .reg_w_en(reg_w_en), .reg_w_rd(reg_w_rd), .reg_w_data(reg_w_data)
    );

    mem_agen agen_i (
        .lat_op(lat_op), .lat_rd(lat_rd),
        .lat_rs1(lat_rs1), .lat_rs2(lat_rs2), .lat_imm(lat_imm),
        .mem_r_en(mem_r_en), .mem_r_rd(mem_r_rd), .mem_r_addr(mem_r_addr),
        .mem_r_strb(mem_r_strb), .mem_r_signed(mem_r_signed),
        .mem_w_en(mem_w_en), .mem_w_addr(mem_w_addr),
        .mem_w_strb(mem_w_strb), .mem_w_data(mem_w_data)
    );

    branch_unit branch_i (
        .lat_pc(lat_pc), .lat_op(lat_op),
        .lat_rs1(lat_rs1), .lat_rs2(lat_rs2), .lat_imm(lat_imm),
        .jmp_do(jmp_do), .jmp_pc(jmp_pc)
    );

endmodule

// ==== verilog/branch_unit.sv ====
module branch_unit (
    input  exec_pkg::xlen_t lat_pc,
    input  exec_pkg::op_t   lat_op,
    input  exec_pkg::xlen_t lat_rs1,
    input  exec_pkg::xlen_t lat_rs2,
    input  exec_pkg::xlen_t lat_imm,
    output logic            jmp_do,
    output exec_pkg::xlen_t jmp_pc
);

    logic [6:0]      major;
    logic [2:0]      f3;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    exec_pkg::xlen_t jalr_sum;

    assign major    = lat_op[16:10];
    assign f3       = lat_op[9:7];
    assign eq       = (lat_rs1 == lat_rs2);
    assign lt_s     = $signed(lat_rs1) < $signed(lat_rs2);
    assign lt_u     = lat_rs1 < lat_rs2;
    assign jalr_sum = lat_rs1 + exec_pkg::imm_i(lat_imm);

    always_comb begin
        jmp_do = 1'b0;
        jmp_pc = '0;
        case (major)
            exec_pkg::OPC_BRANCH: begin
                jmp_pc = lat_pc + exec_pkg::imm_b(lat_imm);     // target even when not taken
                case (f3)
                    exec_pkg::F3_BEQ:  jmp_do = eq;
                    exec_pkg::F3_BNE:  jmp_do = !eq;
                    exec_pkg::F3_BLT:  jmp_do = lt_s;
                    exec_pkg::F3_BGE:  jmp_do = !lt_s;
                    exec_pkg::F3_BLTU: jmp_do = lt_u;
                    exec_pkg::F3_BGEU: jmp_do = !lt_u;
                    default:           jmp_pc = '0;
                endcase
            end
            exec_pkg::OPC_JAL: begin
                jmp_do = 1'b1;
                jmp_pc = lat_pc + lat_imm;      // full decoded immediate
            end
            exec_pkg::OPC_JALR: begin
                if (f3 == exec_pkg::F3_JALR) begin
                    jmp_do = 1'b1;
                    jmp_pc = {jalr_sum[31:1], 1'b0};
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/mem_agen.sv ====
module mem_agen (
    input  exec_pkg::op_t       lat_op,
    input  exec_pkg::reg_addr_t lat_rd,
    input  exec_pkg::xlen_t     lat_rs1,
    input  exec_pkg::xlen_t     lat_rs2,
    input  exec_pkg::xlen_t     lat_imm,
    output logic                mem_r_en,
    output exec_pkg::reg_addr_t mem_r_rd,
    output exec_pkg::xlen_t     mem_r_addr,
    output exec_pkg::strb_t     mem_r_strb,
    output logic                mem_r_signed,
    output logic                mem_w_en,
    output exec_pkg::xlen_t     mem_w_addr,
    output exec_pkg::strb_t     mem_w_strb,
    output exec_pkg::xlen_t     mem_w_data
);

    logic [6:0]      major;
    logic [2:0]      f3;
    exec_pkg::xlen_t addr;
    logic            ld;
    logic            ld_sgn;
    exec_pkg::strb_t ld_strb;
    logic            st;
    exec_pkg::strb_t st_strb;

    assign major = lat_op[16:10];
    assign f3    = lat_op[9:7];
    assign addr  = lat_rs1 + exec_pkg::imm_i(lat_imm);     // same for loads and stores

    always_comb begin
        ld      = (major == exec_pkg::OPC_LOAD);
        ld_sgn  = 1'b0;
        ld_strb = '0;
        case (f3)
            exec_pkg::F3_LB: begin
                ld_strb = exec_pkg::STRB_BYTE;
                ld_sgn  = 1'b1;
            end
            exec_pkg::F3_LH: begin
                ld_strb = exec_pkg::STRB_HALF;
                ld_sgn  = 1'b1;
            end
            exec_pkg::F3_LW:  ld_strb = exec_pkg::STRB_WORD;
            exec_pkg::F3_LBU: ld_strb = exec_pkg::STRB_BYTE;
            exec_pkg::F3_LHU: ld_strb = exec_pkg::STRB_HALF;
            default:          ld = 1'b0;        // no such load
        endcase
    end

    always_comb begin
        st = (major == exec_pkg::OPC_STORE);
        case (f3)
            exec_pkg::F3_SB: st_strb = exec_pkg::STRB_BYTE;
            exec_pkg::F3_SH: st_strb = exec_pkg::STRB_HALF;
            exec_pkg::F3_SW: st_strb = exec_pkg::STRB_WORD;
            default: begin
                st      = 1'b0;
                st_strb = '0;
            end
        endcase
    end

    assign mem_r_en     = ld;
    assign mem_r_rd     = ld ? lat_rd : '0;
    assign mem_r_addr   = ld ? addr : '0;
    assign mem_r_strb   = ld ? ld_strb : '0;
    assign mem_r_signed = ld && ld_sgn;

    assign mem_w_en   = st;
    assign mem_w_addr = st ? addr : '0;
    assign mem_w_strb = st ? st_strb : '0;
    assign mem_w_data = st ? lat_rs2 : '0;

endmodule

// ==== verilog/int_alu.sv ====
module int_alu (
    input  exec_pkg::xlen_t     lat_pc,
    input  exec_pkg::op_t       lat_op,
    input  exec_pkg::reg_addr_t lat_rd,
    input  exec_pkg::xlen_t     lat_rs1,
    input  exec_pkg::xlen_t     lat_rs2,
    input  exec_pkg::xlen_t     lat_imm,
    output logic                reg_w_en,
    output exec_pkg::reg_addr_t reg_w_rd,
    output exec_pkg::xlen_t     reg_w_data
);

    logic [6:0]       major;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic             is_reg;
    logic             alt;
    logic             alu_ok;
    logic             lt_s;
    logic             lt_u;
    exec_pkg::xlen_t  opnd_b;
    exec_pkg::shamt_t shamt;
    exec_pkg::xlen_t  sra_res;
    exec_pkg::xlen_t  alu_res;
    logic             wr;
    exec_pkg::xlen_t  res;

    assign major  = lat_op[16:10];
    assign f3     = lat_op[9:7];
    assign f7     = lat_op[6:0];
    assign is_reg = (major == exec_pkg::OPC_OP);
    assign alt    = (f7 == exec_pkg::FUNCT7_ALT);

    assign opnd_b  = is_reg ? lat_rs2 : exec_pkg::imm_i(lat_imm);
    assign shamt   = is_reg ? lat_rs2[4:0] : lat_imm[4:0];
    assign lt_s    = $signed(lat_rs1) < $signed(opnd_b);
    assign lt_u    = lat_rs1 < opnd_b;
    assign sra_res = $signed(lat_rs1) >>> shamt;

    // funct7 check, only shifts care in the immediate form
    always_comb begin
        if (is_reg) begin
            alu_ok = (f7 == 7'b0) ||
                     (alt && (f3 == exec_pkg::F3_ADD || f3 == exec_pkg::F3_SR));
        end else begin
            case (f3)
                exec_pkg::F3_SLL: alu_ok = (f7 == 7'b0);
                exec_pkg::F3_SR:  alu_ok = (f7 == 7'b0) || alt;
                default:          alu_ok = 1'b1;
            endcase
        end
    end

    always_comb begin
        case (f3)
            exec_pkg::F3_ADD:  alu_res = (is_reg && alt) ? lat_rs1 - opnd_b : lat_rs1 + opnd_b;
            exec_pkg::F3_SLL:  alu_res = lat_rs1 << shamt;
            exec_pkg::F3_SLT:  alu_res = exec_pkg::xlen_t'(lt_s);
            exec_pkg::F3_SLTU: alu_res = exec_pkg::xlen_t'(lt_u);
            exec_pkg::F3_XOR:  alu_res = lat_rs1 ^ opnd_b;
            exec_pkg::F3_SR:   alu_res = alt ? sra_res : lat_rs1 >> shamt;
            exec_pkg::F3_OR:   alu_res = lat_rs1 | opnd_b;
            default:           alu_res = lat_rs1 & opnd_b;     // and
        endcase
    end

    always_comb begin
        wr  = 1'b0;
        res = '0;
        case (major)
            exec_pkg::OPC_OP, exec_pkg::OPC_OP_IMM: begin
                wr  = alu_ok;
                res = alu_res;
            end
            exec_pkg::OPC_LUI: begin
                wr  = 1'b1;
                res = exec_pkg::imm_u(lat_imm);
            end
            exec_pkg::OPC_AUIPC: begin
                wr  = 1'b1;
                res = lat_pc + exec_pkg::imm_u(lat_imm);
            end
            exec_pkg::OPC_JAL: begin
                wr  = 1'b1;
                res = lat_pc + exec_pkg::xlen_t'(4);   // link
            end
            exec_pkg::OPC_JALR: begin
                wr  = (f3 == exec_pkg::F3_JALR);
                res = lat_pc + exec_pkg::xlen_t'(4);
            end
            default: ;      // loads are written back by the memory stage
        endcase
    end

    assign reg_w_en   = wr;
    assign reg_w_rd   = wr ? lat_rd : '0;
    assign reg_w_data = wr ? res : '0;

endmodule

// ==== verilog/exec_latch.sv ====
module exec_latch (
    input  logic                CLK,
    input  logic                rst,
    input  logic                flush,
    input  logic                stall,
    input  logic                mem_wait,
    input  logic                allow,
    input  exec_pkg::xlen_t     pc,
    input  exec_pkg::op_t       opcode,
    input  exec_pkg::reg_addr_t rd_addr,
    input  exec_pkg::xlen_t     rs1_data,
    input  exec_pkg::xlen_t     rs2_data,
    input  exec_pkg::xlen_t     imm,
    output exec_pkg::xlen_t     lat_pc,
    output exec_pkg::op_t       lat_op,
    output exec_pkg::reg_addr_t lat_rd,
    output exec_pkg::xlen_t     lat_rs1,
    output exec_pkg::xlen_t     lat_rs2,
    output exec_pkg::xlen_t     lat_imm
);

    logic bubble;
    logic capture;

    // flush beats mem_wait, mem_wait beats stall and allow
    assign bubble  = rst || flush || (!mem_wait && (stall || !allow));
    assign capture = !mem_wait && !stall && allow;

    always_ff @(posedge CLK) begin
        if (bubble) begin
            lat_pc  <= '0;
            lat_op  <= '0;      // major 0 decodes to nothing
            lat_rd  <= '0;
            lat_rs1 <= '0;
            lat_rs2 <= '0;
            lat_imm <= '0;
        end else if (capture) begin
            lat_pc  <= pc;
            lat_op  <= opcode;
            lat_rd  <= rd_addr;
            lat_rs1 <= rs1_data;
            lat_rs2 <= rs2_data;
            lat_imm <= imm;
        end
        // else mem_wait, hold
    end

endmodule

// ==== verilog/exec_pkg.sv ====
package exec_pkg;

    localparam int XLEN = 32;
    localparam int OP_W = 17;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [OP_W-1:0] op_t;      // {major, funct3, funct7}
    typedef logic [3:0]      strb_t;
    typedef logic [4:0]      shamt_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD  = 3'b000;   // add, sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // srl, sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_LB   = 3'b000;
    localparam logic [2:0] F3_LH   = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_LHU  = 3'b101;
    localparam logic [2:0] F3_SB   = 3'b000;
    localparam logic [2:0] F3_SH   = 3'b001;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    localparam strb_t STRB_BYTE = 4'b0001;
    localparam strb_t STRB_HALF = 4'b0011;
    localparam strb_t STRB_WORD = 4'b1111;

    function automatic xlen_t imm_i(input xlen_t imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    function automatic xlen_t imm_b(input xlen_t imm);
        return {{19{imm[12]}}, imm[12:1], 1'b0};
    endfunction

    function automatic xlen_t imm_u(input xlen_t imm);
        return {imm[31:12], 12'b0};
    endfunction

endpackage
